/* byte_memory.sv */
// Byte-addressed big-endian memory with fetch, load, store and host ports
`default_nettype none

module byte_memory #(
    parameter int MEM_BYTES = 16384
) (
    input  wire logic                  clk,
    input  wire tinker_pkg::addr_t     fetch_addr,
    output logic [tinker_pkg::ILEN-1:0] fetch_word,
    dmem_if.memory                     dmem,
    input  wire logic                  host_we,
    input  wire tinker_pkg::addr_t     host_addr,
    input  wire logic [7:0]            host_wdata,
    output logic [7:0]                 host_rdata
);

    localparam int AW = $clog2(MEM_BYTES);  // Upper address bits ignored

    logic [7:0]    mem [MEM_BYTES];
    logic [AW-1:0] fa, la, sa, ha;

    assign fa = fetch_addr[AW-1:0];
    assign la = dmem.ld_addr[AW-1:0];
    assign sa = dmem.st_addr[AW-1:0];
    assign ha = host_addr[AW-1:0];

    // ------------------------------
    // Reads, most significant byte first
    // ------------------------------
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fetch_word[tinker_pkg::ILEN-1-8*i -: 8] = mem[fa + AW'(i)];
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            dmem.ld_data[tinker_pkg::XLEN-1-8*i -: 8] = mem[la + AW'(i)];
        end
    end

    assign host_rdata = mem[ha];

    // ------------------------------
    // Writes, host first
    // ------------------------------
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[ha] <= host_wdata;  // Program load and debug pokes
        end else if (dmem.st_we) begin
            for (int i = 0; i < 8; i++) begin
                mem[sa + AW'(i)] <= dmem.st_data[tinker_pkg::XLEN-1-8*i -: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
// Integer ALU, branch resolution, memory address and write-back control
`default_nettype none

module execute_stage (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic exec_en,
    operand_if.sink   ops,
    result_if.source  res
);

    localparam int XLEN  = tinker_pkg::XLEN;
    localparam int LIT_W = tinker_pkg::LIT_W;
    localparam int AW    = tinker_pkg::ADDR_W;

    tinker_pkg::word_t lit_sx, lit_zx, alu_val, ld_sum, st_sum;
    tinker_pkg::addr_t pc_plus4, next_pc;
    logic              wb_we;

    assign lit_sx = {{(XLEN-LIT_W){ops.lit[LIT_W-1]}}, ops.lit};
    assign lit_zx = {{(XLEN-LIT_W){1'b0}}, ops.lit};

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        wb_we = 1'b1;  // Most ops write rd
        case (ops.opcode)
            tinker_pkg::OP_ADD:    alu_val = ops.rs_val + ops.rt_val;
            tinker_pkg::OP_ADDI:   alu_val = ops.rd_val + lit_sx;
            tinker_pkg::OP_SUB:    alu_val = ops.rs_val - ops.rt_val;
            tinker_pkg::OP_SUBI:   alu_val = ops.rd_val - lit_zx;
            tinker_pkg::OP_MUL:    alu_val = ops.rs_val * ops.rt_val;  // Low half
            tinker_pkg::OP_AND:    alu_val = ops.rs_val & ops.rt_val;
            tinker_pkg::OP_OR:     alu_val = ops.rs_val | ops.rt_val;
            tinker_pkg::OP_XOR:    alu_val = ops.rs_val ^ ops.rt_val;
            tinker_pkg::OP_NOT:    alu_val = ~ops.rs_val;
            tinker_pkg::OP_SHFTR:  alu_val = ops.rs_val >> ops.rt_val;
            tinker_pkg::OP_SHFTL:  alu_val = ops.rs_val << ops.rt_val;
            tinker_pkg::OP_SHFTRI: alu_val = ops.rd_val >> ops.lit;
            tinker_pkg::OP_SHFTLI: alu_val = ops.rd_val << ops.lit;
            tinker_pkg::OP_MOVR:   alu_val = ops.rs_val;
            tinker_pkg::OP_MOVL:   alu_val = {ops.rd_val[XLEN-1:LIT_W], ops.lit};
            tinker_pkg::OP_LOAD:   alu_val = '0;  // Replaced in memory phase
            default: begin
                alu_val = '0;
                wb_we   = 1'b0;  // Branches, store, unknown
            end
        endcase
    end

    // ------------------------------
    // Next PC
    // ------------------------------
    assign pc_plus4 = ops.pc + AW'(4);

    always_comb begin
        case (ops.opcode)
            tinker_pkg::OP_BR:   next_pc = ops.rd_val[AW-1:0];
            tinker_pkg::OP_BRR:  next_pc = ops.pc + ops.rd_val[AW-1:0];
            tinker_pkg::OP_BRRL: next_pc = ops.pc + lit_sx[AW-1:0];
            tinker_pkg::OP_BRNZ:
                next_pc = (ops.rs_val != '0) ? ops.rd_val[AW-1:0] : pc_plus4;
            tinker_pkg::OP_BRGT:
                next_pc = ($signed(ops.rs_val) > $signed(ops.rt_val)) ?
                          ops.rd_val[AW-1:0] : pc_plus4;
            default:             next_pc = pc_plus4;
        endcase
    end

    // Load base rs, store base rd
    assign ld_sum = ops.rs_val + lit_sx;
    assign st_sum = ops.rd_val + lit_sx;

    // Control results
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res.wb_we    <= 1'b0;
            res.wb_idx   <= '0;
            res.is_load  <= 1'b0;
            res.is_store <= 1'b0;
            res.next_pc  <= tinker_pkg::RESET_PC;
        end else if (exec_en) begin
            res.wb_we    <= wb_we;
            res.wb_idx   <= ops.rd;
            res.is_load  <= (ops.opcode == tinker_pkg::OP_LOAD);
            res.is_store <= (ops.opcode == tinker_pkg::OP_STORE);
            res.next_pc  <= next_pc;
        end
    end

    // Data results
    always_ff @(posedge clk) begin
        if (exec_en) begin
            res.wb_val   <= alu_val;
            res.mem_addr <= (ops.opcode == tinker_pkg::OP_STORE) ?
                            st_sum[AW-1:0] : ld_sum[AW-1:0];
            res.st_data  <= ops.rs_val;
        end
    end

endmodule

`default_nettype wire

/* fetch_sequencer.sv */
// Phase FSM, program counter, instruction register and halt detection
`default_nettype none

module fetch_sequencer (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [tinker_pkg::ILEN-1:0] fetch_word,
    output tinker_pkg::addr_t           fetch_addr,
    output logic [tinker_pkg::ILEN-1:0] instr,
    result_if.sequencer                 res,
    output logic                        decode_en,
    output logic                        exec_en,
    output logic                        mem_en,
    output logic                        wb_en,
    output logic                        hlt
);

    tinker_pkg::phase_t          phase;
    tinker_pkg::addr_t           pc;
    logic [tinker_pkg::ILEN-1:0] ir;
    logic                        is_halt;

    // Halt opcode, or an empty word
    assign is_halt = (ir[31:27] == tinker_pkg::OP_HALT) || (ir == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= tinker_pkg::PH_FETCH;
            pc    <= tinker_pkg::RESET_PC;
            ir    <= '0;
            hlt   <= 1'b0;
        end else if (!hlt) begin
            case (phase)
                tinker_pkg::PH_FETCH: begin
                    ir    <= fetch_word;
                    phase <= tinker_pkg::PH_OPERAND;
                end
                tinker_pkg::PH_OPERAND: begin
                    if (is_halt) hlt <= 1'b1;  // Sticky, phase stays put
                    else phase <= tinker_pkg::PH_EXECUTE;
                end
                tinker_pkg::PH_EXECUTE: phase <= tinker_pkg::PH_MEMORY;
                tinker_pkg::PH_MEMORY:  phase <= tinker_pkg::PH_WRITEBACK;
                tinker_pkg::PH_WRITEBACK: begin
                    pc    <= res.next_pc;  // Branch or PC+4
                    phase <= tinker_pkg::PH_FETCH;
                end
                default: phase <= tinker_pkg::PH_FETCH;
            endcase
        end
    end

    assign fetch_addr = pc;
    assign instr      = ir;

    // One-hot strobes, quiet once halted
    assign decode_en = (phase == tinker_pkg::PH_OPERAND)   && !hlt;
    assign exec_en   = (phase == tinker_pkg::PH_EXECUTE)   && !hlt;
    assign mem_en    = (phase == tinker_pkg::PH_MEMORY)    && !hlt;
    assign wb_en     = (phase == tinker_pkg::PH_WRITEBACK) && !hlt;

endmodule

`default_nettype wire

/* memory_stage.sv */
// Store strobe, load capture and register write-back drive
`default_nettype none

module memory_stage (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           mem_en,
    input  wire logic           wb_en,
    result_if.sink              res,
    dmem_if.client              dmem,
    output logic                w_we,
    output tinker_pkg::reg_idx_t w_idx,
    output tinker_pkg::word_t   w_data
);

    tinker_pkg::word_t wb_val_q;
    logic              wb_pend;  // Write-back owed by this instruction

    assign dmem.ld_addr = res.mem_addr;
    assign dmem.st_addr = res.mem_addr;
    assign dmem.st_data = res.st_data;
    assign dmem.st_we   = mem_en && res.is_store;  // Single memory-phase cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) wb_pend <= 1'b0;
        else if (mem_en) wb_pend <= res.wb_we;
    end

    always_ff @(posedge clk) begin
        if (mem_en) wb_val_q <= res.is_load ? dmem.ld_data : res.wb_val;
    end

    assign w_we   = wb_en && wb_pend;
    assign w_idx  = res.wb_idx;
    assign w_data = wb_val_q;

endmodule

`default_nettype wire

/* operand_stage.sv */
// Instruction field split, register read indices and operand capture
`default_nettype none

module operand_stage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   decode_en,
    input  wire logic [tinker_pkg::ILEN-1:0] instr,
    input  wire tinker_pkg::addr_t      pc,
    output tinker_pkg::reg_idx_t        rd_idx,
    output tinker_pkg::reg_idx_t        rs_idx,
    output tinker_pkg::reg_idx_t        rt_idx,
    input  wire tinker_pkg::word_t      rd_val,
    input  wire tinker_pkg::word_t      rs_val,
    input  wire tinker_pkg::word_t      rt_val,
    operand_if.source                   ops
);

    // Field layout: op[31:27] rd[26:22] rs[21:17] rt[16:12] L[11:0]
    assign rd_idx = instr[26:22];
    assign rs_idx = instr[21:17];
    assign rt_idx = instr[16:12];

    // Control part
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ops.opcode <= tinker_pkg::OP_AND;
            ops.rd     <= '0;
        end else if (decode_en) begin
            ops.opcode <= tinker_pkg::opcode_t'(instr[31:27]);
            ops.rd     <= rd_idx;
        end
    end

    // Payload, valid from the execute phase on
    always_ff @(posedge clk) begin
        if (decode_en) begin
            ops.lit    <= instr[tinker_pkg::LIT_W-1:0];
            ops.pc     <= pc;
            ops.rd_val <= rd_val;
            ops.rs_val <= rs_val;
            ops.rt_val <= rt_val;
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
// 32 x 64-bit register file, three async read ports, one write port
`default_nettype none

module register_file (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire tinker_pkg::reg_idx_t rd_idx,
    input  wire tinker_pkg::reg_idx_t rs_idx,
    input  wire tinker_pkg::reg_idx_t rt_idx,
    output tinker_pkg::word_t         rd_val,
    output tinker_pkg::word_t         rs_val,
    output tinker_pkg::word_t         rt_val,
    input  wire logic                 we,
    input  wire tinker_pkg::reg_idx_t w_idx,
    input  wire tinker_pkg::word_t    w_data
);

    tinker_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && w_idx != '0) begin
            regs[w_idx] <= w_data;  // r0 stays zero
        end
    end

    assign rd_val = regs[rd_idx];
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

`default_nettype wire

/* tb_tinker_core.sv */
// Testbench with assembler helpers, LFSR, program loader, stimulus and checks
`default_nettype none

module tb_tinker_core;

    localparam int  DLY         = 10;  // Drive offset after the rising edge
    localparam int  PROG_MAX    = 64;  // Words per program
    localparam int  READS_MAX   = 16;  // Doublewords read back per program
    localparam int  N_PROGS     = 6;
    localparam int  PROG_CYCLES = PROG_MAX * (4 + 5) + READS_MAX * 8 + 50;

    logic        clk;
    logic        reset;
    logic        host_we;
    logic [31:0] host_addr;
    logic [7:0]  host_wdata;
    logic [7:0]  host_rdata;
    logic        hlt;

    logic [31:0] prog [$];             // Program under construction
    logic [31:0] area;                 // Data area of the current program
    logic [15:0] lfsr = 16'd18;
    int          checks = 0;
    int          errors = 0;

    tinker_core #(.MEM_BYTES(16384)) i_tinker_core (
        .clk        (clk),
        .reset      (reset),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] l);
        return {{52{l[11]}}, l};
    endfunction

    // op[31:27] rd[26:22] rs[21:17] rt[16:12] L[11:0]
    function automatic logic [31:0] encode(input logic [4:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [11:0] lit);
        return {op, rd, rs, rt, lit};
    endfunction

    task automatic emit(input tinker_pkg::opcode_t op, input logic [4:0] rd,
                        input logic [4:0] rs, input logic [4:0] rt, input logic [11:0] lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endtask

    // r30 = 0x3000 + 0x100*p, one area per program
    task automatic set_base(input int p);
        emit(tinker_pkg::OP_MOVL, 30, 0, 0, 12'(12'h300 + 16 * p));
        emit(tinker_pkg::OP_SHFTLI, 30, 0, 0, 12'd4);
        area = 32'h3000 + 32'(256 * p);
    endtask

    task automatic store_slot(input logic [4:0] rs, input int slot);
        emit(tinker_pkg::OP_STORE, 30, rs, 0, 12'(8 * slot));
    endtask

    // Builds a 64-bit value from six 12-bit chunks in a zeroed register
    task automatic build_value(input logic [4:0] r, output logic [63:0] val);
        logic [11:0] lit;
        val = '0;
        for (int k = 0; k < 6; k++) begin
            lit = 12'(rand_bits(12));
            if (k > 0) begin
                emit(tinker_pkg::OP_SHFTLI, r, 0, 0, 12'd12);
                val = val << 12;
            end
            emit(tinker_pkg::OP_MOVL, r, 0, 0, lit);
            val = {val[63:12], lit};
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_byte(input logic [31:0] addr, output logic [7:0] b);
        @(posedge clk);
        #DLY host_addr = addr;
        @(negedge clk);
        b = host_rdata;
    endtask

    task automatic read_dword(input logic [31:0] addr, output logic [63:0] v);
        logic [7:0] b;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            read_byte(addr + 32'(i), b);
            v = {v[55:0], b};  // Lowest address is the MSB
        end
    endtask

    task automatic check_slot(input string what, input int slot, input logic [63:0] exp);
        logic [63:0] got;
        read_dword(area + 32'(8 * slot), got);
        check_value(what, got, exp);
    endtask

    // Load under reset, release, count edges up to hlt
    task automatic run_program(input int n_before_halt);
        int edges;
        if (prog.size() > PROG_MAX) begin
            errors++;
            $display("Program of %0d words does not fit the cycle budget", prog.size());
        end
        @(posedge clk);
        #DLY reset = 1'b1;
        foreach (prog[i]) begin
            for (int b = 0; b < 4; b++) begin
                @(posedge clk);
                #DLY host_we = 1'b1;
                host_addr  = tinker_pkg::RESET_PC + 32'(4 * i + b);
                host_wdata = prog[i][31 - 8 * b -: 8];
            end
        end
        @(posedge clk);
        #DLY host_we = 1'b0;
        repeat (2) @(posedge clk);
        #DLY reset = 1'b0;
        edges = 0;
        while (hlt !== 1'b1) begin
            @(posedge clk);
            #DLY edges++;
        end
        if (n_before_halt >= 0) check_value("hlt edge", 64'(edges), 64'(5 * n_before_halt + 2));
        repeat (5) begin  // Sticky
            @(posedge clk);
            #DLY check_value("hlt held", 64'(hlt), 64'd1);
        end
    endtask

    // ------------------------------
    // Programs
    // ------------------------------
    task automatic alu_program();
        logic [63:0] a, b;
        logic [11:0] l1, l2;
        prog.delete();
        set_base(0);
        build_value(1, a);
        build_value(2, b);
        l1 = 12'(rand_bits(12));
        l2 = 12'(rand_bits(12));
        emit(tinker_pkg::OP_ADD, 3, 1, 2, 0);
        store_slot(3, 0);
        emit(tinker_pkg::OP_MOVR, 4, 1, 0, 0);
        emit(tinker_pkg::OP_ADDI, 4, 0, 0, l1);
        store_slot(4, 1);
        emit(tinker_pkg::OP_SUB, 5, 1, 2, 0);
        store_slot(5, 2);
        emit(tinker_pkg::OP_MOVR, 6, 1, 0, 0);
        emit(tinker_pkg::OP_SUBI, 6, 0, 0, l2);
        store_slot(6, 3);
        emit(tinker_pkg::OP_MUL, 7, 1, 2, 0);
        store_slot(7, 4);
        emit(tinker_pkg::OP_AND, 8, 1, 2, 0);
        store_slot(8, 5);
        emit(tinker_pkg::OP_OR, 9, 1, 2, 0);
        store_slot(9, 6);
        emit(tinker_pkg::OP_XOR, 10, 1, 2, 0);
        store_slot(10, 7);
        emit(tinker_pkg::OP_NOT, 11, 1, 0, 0);
        store_slot(11, 8);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        run_program(prog.size() - 1);
        check_slot("add", 0, a + b);
        check_slot("addi", 1, a + sext12(l1));      // Signed literal
        check_slot("sub", 2, a - b);
        check_slot("subi", 3, a - {52'd0, l2});     // Unsigned literal
        check_slot("mul", 4, a * b);
        check_slot("and", 5, a & b);
        check_slot("or", 6, a | b);
        check_slot("xor", 7, a ^ b);
        check_slot("not", 8, ~a);
    endtask

    task automatic shift_program();
        logic [63:0] a, amt;
        logic [11:0] s2, s3, l4;
        prog.delete();
        set_base(1);
        build_value(1, a);
        amt = rand_bits(6);
        s2  = 12'(rand_bits(6));
        s3  = 12'(rand_bits(6));
        l4  = 12'(rand_bits(12));
        emit(tinker_pkg::OP_MOVL, 2, 0, 0, amt[11:0]);
        emit(tinker_pkg::OP_SHFTR, 3, 1, 2, 0);
        store_slot(3, 0);
        emit(tinker_pkg::OP_SHFTL, 4, 1, 2, 0);
        store_slot(4, 1);
        emit(tinker_pkg::OP_MOVR, 5, 1, 0, 0);
        emit(tinker_pkg::OP_SHFTRI, 5, 0, 0, s2);
        store_slot(5, 2);
        emit(tinker_pkg::OP_MOVR, 6, 1, 0, 0);
        emit(tinker_pkg::OP_SHFTLI, 6, 0, 0, s3);
        store_slot(6, 3);
        emit(tinker_pkg::OP_MOVR, 7, 1, 0, 0);
        store_slot(7, 4);
        emit(tinker_pkg::OP_MOVR, 8, 1, 0, 0);
        emit(tinker_pkg::OP_MOVL, 8, 0, 0, l4);
        store_slot(8, 5);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        run_program(prog.size() - 1);
        check_slot("shftr", 0, a >> amt);
        check_slot("shftl", 1, a << amt);
        check_slot("shftri", 2, a >> s2);
        check_slot("shftli", 3, a << s3);
        check_slot("mov rd,rs", 4, a);
        check_slot("mov rd,L", 5, {a[63:12], l4});  // Upper bits untouched
    endtask

    task automatic memory_program();
        logic [63:0] a;
        logic [7:0]  b;
        prog.delete();
        set_base(2);
        build_value(1, a);
        store_slot(1, 0);
        emit(tinker_pkg::OP_LOAD, 5, 30, 0, 0);    // r5 = mem[r30]
        store_slot(5, 1);
        emit(tinker_pkg::OP_MOVR, 29, 30, 0, 0);
        emit(tinker_pkg::OP_ADDI, 29, 0, 0, 12'h020);
        emit(tinker_pkg::OP_STORE, 29, 5, 0, 12'hFF0);  // Offset -16, slot 2
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        run_program(prog.size() - 1);
        check_slot("store", 0, a);
        check_slot("load then store", 1, a);
        check_slot("negative offset", 2, a);
        for (int i = 0; i < 8; i++) begin
            read_byte(area + 32'(i), b);
            check_value($sformatf("byte %0d", i), 64'(b), 64'(a[63 - 8 * i -: 8]));
        end
    endtask

    // Target register = address four words ahead of the first setup word
    task automatic aim(input logic [4:0] r);
        int p;
        p = prog.size();
        emit(tinker_pkg::OP_MOVR, r, 11, 0, 0);
        emit(tinker_pkg::OP_ADDI, r, 0, 0, 12'(4 * (p + 3)));
    endtask

    task automatic mark(input int slot);
        emit(tinker_pkg::OP_MOVL, 20, 0, 0, 12'(slot + 1));
        store_slot(20, slot);
    endtask

    // Wrong path either halts early at a trap or skips a marker
    task automatic branch_program();
        prog.delete();
        emit(tinker_pkg::OP_BRRL, 0, 0, 0, 12'd8);   // Over the trap
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);      // Trap at 0x2004
        set_base(3);
        emit(tinker_pkg::OP_MOVL, 21, 0, 0, 12'hBAD);
        for (int s = 0; s < 8; s++) store_slot(21, s);
        emit(tinker_pkg::OP_MOVL, 11, 0, 0, 12'h200);
        emit(tinker_pkg::OP_SHFTLI, 11, 0, 0, 12'd4);
        emit(tinker_pkg::OP_ADDI, 11, 0, 0, 12'd4);   // r11 = trap
        emit(tinker_pkg::OP_MOVL, 1, 0, 0, 12'd5);
        emit(tinker_pkg::OP_SUBI, 2, 0, 0, 12'd3);    // r2 = -3
        emit(tinker_pkg::OP_MOVL, 13, 0, 0, 12'd8);
        mark(0);
        aim(12);
        emit(tinker_pkg::OP_BR, 12, 0, 0, 0);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        mark(1);
        emit(tinker_pkg::OP_BRR, 13, 0, 0, 0);      // PC + 8
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        mark(2);
        aim(12);
        emit(tinker_pkg::OP_BRNZ, 12, 1, 0, 0);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        mark(3);
        emit(tinker_pkg::OP_BRNZ, 11, 0, 0, 0);     // r0 is zero
        mark(4);
        aim(12);
        emit(tinker_pkg::OP_BRGT, 12, 1, 2, 0);     // 5 > -3 only when signed
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        mark(5);
        emit(tinker_pkg::OP_BRGT, 11, 2, 1, 0);
        mark(6);
        emit(tinker_pkg::OP_BRGT, 11, 1, 1, 0);     // Equal, not taken
        mark(7);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        run_program(-1);
        check_slot("brr-literal taken", 0, 64'd1);
        check_slot("br taken", 1, 64'd2);
        check_slot("brr-register taken", 2, 64'd3);
        check_slot("brnz taken", 3, 64'd4);
        check_slot("brnz not taken", 4, 64'd5);
        check_slot("brgt taken", 5, 64'd6);
        check_slot("brgt not taken", 6, 64'd7);
        check_slot("brgt equal", 7, 64'd8);
    endtask

    task automatic r0_program();
        logic [11:0] l;
        int          halt_at;
        prog.delete();
        l = 12'(rand_bits(12));
        set_base(4);
        emit(tinker_pkg::OP_MOVL, 1, 0, 0, l);
        emit(tinker_pkg::OP_MOVL, 0, 0, 0, 12'hABC);  // r0 writes dropped
        emit(tinker_pkg::OP_ADD, 0, 1, 1, 0);
        store_slot(0, 0);
        store_slot(1, 1);
        emit(tinker_pkg::OP_MOVL, 2, 0, 0, 12'h055);
        store_slot(2, 2);
        halt_at = prog.size();
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        store_slot(1, 2);                           // Never reached
        run_program(halt_at);
        check_slot("r0 stays zero", 0, 64'd0);
        check_slot("r1", 1, {52'd0, l});
        check_slot("frozen after halt", 2, 64'h55);
    endtask

    task automatic zero_halt_program();
        int halt_at;
        prog.delete();
        set_base(5);
        emit(tinker_pkg::OP_MOVL, 2, 0, 0, 12'h077);
        store_slot(2, 0);
        halt_at = prog.size();
        prog.push_back(32'h0000_0000);
        emit(tinker_pkg::OP_MOVL, 2, 0, 0, 12'h088);
        store_slot(2, 0);
        emit(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        run_program(halt_at);
        check_slot("zero word halts", 0, 64'h77);
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        reset      = 1'b1;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        area       = '0;
        alu_program();
        shift_program();
        memory_program();
        branch_program();
        r0_program();
        zero_halt_program();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (N_PROGS * PROG_CYCLES) @(posedge clk);
        $display("Timeout: hlt never came within %0d cycles", N_PROGS * PROG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tinker_core.sv */
// Tinker multicycle core top level with memory and host byte port
`default_nettype none

module tinker_core #(
    parameter int MEM_BYTES = 16384
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              host_we,
    input  wire tinker_pkg::addr_t host_addr,
    input  wire logic [7:0]        host_wdata,
    output logic [7:0]             host_rdata,
    output logic                   hlt
);

    // ------------------------------
    // Internal connections
    // ------------------------------
    tinker_pkg::addr_t           fetch_addr;
    logic [tinker_pkg::ILEN-1:0] fetch_word, instr;
    logic                        decode_en, exec_en, mem_en, wb_en;
    tinker_pkg::reg_idx_t        rd_idx, rs_idx, rt_idx, w_idx;
    tinker_pkg::word_t           rd_val, rs_val, rt_val, w_data;
    logic                        w_we;

    operand_if ops ();
    result_if  res ();
    dmem_if    dmem ();

    byte_memory #(.MEM_BYTES(MEM_BYTES)) i_byte_memory (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .dmem       (dmem.memory),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    fetch_sequencer i_fetch_sequencer (
        .clk        (clk),
        .reset      (reset),
        .fetch_word (fetch_word),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .res        (res.sequencer),
        .decode_en  (decode_en),
        .exec_en    (exec_en),
        .mem_en     (mem_en),
        .wb_en      (wb_en),
        .hlt        (hlt)
    );

    register_file i_register_file (
        .clk    (clk),
        .reset  (reset),
        .rd_idx (rd_idx),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rd_val (rd_val),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .we     (w_we),
        .w_idx  (w_idx),
        .w_data (w_data)
    );

    // PC of the current instruction is the fetch address
    operand_stage i_operand_stage (
        .clk       (clk),
        .reset     (reset),
        .decode_en (decode_en),
        .instr     (instr),
        .pc        (fetch_addr),
        .rd_idx    (rd_idx),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rd_val    (rd_val),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .ops       (ops.source)
    );

    execute_stage i_execute_stage (
        .clk     (clk),
        .reset   (reset),
        .exec_en (exec_en),
        .ops     (ops.sink),
        .res     (res.source)
    );

    memory_stage i_memory_stage (
        .clk    (clk),
        .reset  (reset),
        .mem_en (mem_en),
        .wb_en  (wb_en),
        .res    (res.sink),
        .dmem   (dmem.client),
        .w_we   (w_we),
        .w_idx  (w_idx),
        .w_data (w_data)
    );

endmodule

`default_nettype wire

/* tinker_ifs.sv */
// Interfaces operand_if, result_if and dmem_if
`default_nettype none

// Decoded fields and operand values, operand phase to execute phase
interface operand_if;
    tinker_pkg::opcode_t  opcode;
    tinker_pkg::reg_idx_t rd;
    logic [tinker_pkg::LIT_W-1:0] lit;
    tinker_pkg::addr_t    pc;
    tinker_pkg::word_t    rd_val;
    tinker_pkg::word_t    rs_val;
    tinker_pkg::word_t    rt_val;

    modport source (output opcode, rd, lit, pc, rd_val, rs_val, rt_val);
    modport sink   (input  opcode, rd, lit, pc, rd_val, rs_val, rt_val);
endinterface

// Execute results, held from the end of the execute phase
interface result_if;
    tinker_pkg::word_t    wb_val;
    tinker_pkg::reg_idx_t wb_idx;
    logic                 wb_we;
    logic                 is_load;
    logic                 is_store;
    tinker_pkg::addr_t    mem_addr;
    tinker_pkg::word_t    st_data;
    tinker_pkg::addr_t    next_pc;

    modport source (output wb_val, wb_idx, wb_we, is_load, is_store, mem_addr, st_data, next_pc);
    modport sink   (input  wb_val, wb_idx, wb_we, is_load, is_store, mem_addr, st_data);
    modport sequencer (input next_pc);
endinterface

// Data side of the memory
interface dmem_if;
    tinker_pkg::addr_t ld_addr;
    tinker_pkg::word_t ld_data;   // Combinational
    logic              st_we;     // One cycle, memory phase
    tinker_pkg::addr_t st_addr;
    tinker_pkg::word_t st_data;

    modport client (output ld_addr, st_we, st_addr, st_data, input ld_data);
    modport memory (input ld_addr, st_we, st_addr, st_data, output ld_data);
endinterface

`default_nettype wire

/* tinker_pkg.sv */
// Tinker widths, data types, opcode and phase encodings, reset PC
`default_nettype none

package tinker_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN      = 64;  // Data and register width
    localparam int ILEN      = 32;  // Instruction word
    localparam int ADDR_W    = 32;  // Byte address
    localparam int REG_IDX_W = 5;
    localparam int LIT_W     = 12;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Instruction bits [31:27]
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,  // Absolute, target in rd
        OP_BRR    = 5'h09,  // PC relative by rd
        OP_BRRL   = 5'h0A,  // PC relative by literal
        OP_BRNZ   = 5'h0B,
        OP_BRGT   = 5'h0E,
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10,  // mov rd, (rs)(L)
        OP_MOVR   = 5'h11,  // mov rd, rs
        OP_MOVL   = 5'h12,  // mov rd, L
        OP_STORE  = 5'h13,  // mov (rd)(L), rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B,
        OP_MUL    = 5'h1C
    } opcode_t;

    // One instruction in flight, one phase per cycle
    typedef enum logic [2:0] {
        PH_FETCH     = 3'd0,
        PH_OPERAND   = 3'd1,
        PH_EXECUTE   = 3'd2,
        PH_MEMORY    = 3'd3,
        PH_WRITEBACK = 3'd4
    } phase_t;

    localparam addr_t RESET_PC = 32'h0000_2000;  // First fetch

endpackage

`default_nettype wire

/* vlog.f */
tinker_pkg.sv
tinker_ifs.sv
byte_memory.sv
fetch_sequencer.sv
register_file.sv
operand_stage.sv
execute_stage.sv
memory_stage.sv
tinker_core.sv
tb_tinker_core.sv
